/* dv/scr_link_tx_sva.sv */
// Output stream assertions
`timescale 1ns/100ps

module scr_link_tx_sva import scr_frame_pkg::*; (
    input logic      clk,
    input logic      rst,
    input logic      in_last,
    input logic      in_ready,
    input logic      adv,
    input out_beat_t out_beat,
    input logic      out_valid,
    input logic      out_ready
);

    // a stalled beat keeps its slot
    a_valid_hold: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid)
        else $error("out_valid dropped before the beat transferred");

    // and keeps its contents
    a_beat_hold: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> $stable(out_beat))
        else $error("out_beat changed while stalled");

    // the CRC beat is owed right after the last word of a frame
    a_crc_blocks_input: assert property (@(posedge clk) disable iff (rst)
        adv && in_last |=> !in_ready)
        else $error("in_ready high while the CRC beat was still pending");

    a_reset_idle: assert property (@(posedge clk)
        rst |=> !out_valid)
        else $error("out_valid high after reset");

endmodule : scr_link_tx_sva

bind frame_combiner scr_link_tx_sva u_sva (
    .clk       (clk),
    .rst       (rst),
    .in_last   (in_last),
    .in_ready  (in_ready),
    .adv       (adv),
    .out_beat  (out_beat),
    .out_valid (out_valid),
    .out_ready (out_ready)
);

/* dv/scr_link_tx_tb.sv */
// Serial link transmit testbench
`timescale 1ns/100ps

module scr_link_tx_tb import scr_frame_pkg::*; ();

    localparam int unsigned DATA_W     = 64; // payload width under test
    localparam int unsigned NUM_FRAMES = 9;  // rows in the frame table

    // one frame of stimulus with its expected beat count
    typedef struct packed {
        int unsigned len;       // data words in the frame
        logic [63:0] first;     // first word before the LFSR words
        logic        stall;     // random out_ready while this frame is sent
        int unsigned gap;       // idle cycles with in_valid low before the frame
        int unsigned exp_beats; // data beats plus the CRC beat
    } frame_row_t;

    frame_row_t frame_table [NUM_FRAMES] = '{
        '{32'd4, 64'h0123_4567_89ab_cdef, 1'b0, 32'd0, 32'd5},
        '{32'd1, 64'h0000_0000_0000_0000, 1'b0, 32'd0, 32'd2}, // single word frames back to back
        '{32'd1, 64'hffff_ffff_ffff_ffff, 1'b0, 32'd0, 32'd2},
        '{32'd3, 64'hdead_beef_cafe_f00d, 1'b0, 32'd2, 32'd4}, // idle gap first
        '{32'd6, 64'h1122_3344_5566_7788, 1'b1, 32'd0, 32'd7}, // stalled output
        '{32'd1, 64'h8000_0000_0000_0001, 1'b1, 32'd0, 32'd2},
        '{32'd8, 64'h0f0f_0f0f_f0f0_f0f0, 1'b1, 32'd1, 32'd9},
        '{32'd2, 64'h5555_aaaa_5555_aaaa, 1'b1, 32'd0, 32'd3},
        '{32'd5, 64'h7e57_0000_0000_0e7d, 1'b0, 32'd0, 32'd6}  // back to full rate
    };

    logic      clk;
    logic      rst;
    in_beat_t  in_beat;
    logic      in_valid;
    logic      in_ready;
    out_beat_t out_beat;
    logic      out_valid;
    logic      out_ready;

    logic [57:0] scr_state   = '1;            // model scrambler state that is never reseeded
    logic [31:0] crc_state   = 32'hffff_ffff; // reflected model remainder
    logic [31:0] data_rnd    = 32'h42e3_c749; // word pattern generator
    logic [31:0] ready_rnd   = 32'h42e3_c749; // out_ready pattern generator
    logic        stall_en    = 1'b0;          // random out_ready enable
    logic        crc_pending = 1'b0;          // last word taken and CRC not yet in the slot
    int unsigned frame_beats = 0;             // beats seen in the current frame
    out_beat_t   exp_q [$];                   // expected output beats in order
    int unsigned beats_q [$];                 // expected beat count per frame

    scr_link_tx #(
        .DATA_W (DATA_W)
    ) i_dut (
        .clk       (clk),
        .rst       (rst),
        .in_beat   (in_beat),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_beat  (out_beat),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_equal(input string name, input logic [63:0] got,
                               input logic [63:0] want);
        if (got !== want) begin
            fail_run($sformatf("Error: %s is 0x%0h, expected 0x%0h", name, got, want));
        end
    endtask

    // fibonacci x^32 + x^22 + x^2 + x + 1 with the new bit landing in bit 0
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [63:0] next_data_word();
        logic [63:0] w;
        for (int b = 0; b < 64; b++) begin
            data_rnd = lfsr_next(data_rnd); // one step per bit
            w[b]     = data_rnd[0];
        end
        return w;
    endfunction

    // x^58 + x^39 + 1 from bit 0 up with the output bit shifted back in
    function automatic logic [63:0] scramble_word(input logic [63:0] d);
        logic [63:0] s_out;
        logic        b;
        for (int i = 0; i < 64; i++) begin
            b         = d[i] ^ scr_state[38] ^ scr_state[57];
            s_out[i]  = b;
            scr_state = {scr_state[56:0], b};
        end
        return s_out;
    endfunction

    // reflected CRC-32 one bit at a time from bit 0
    function automatic void crc_fold(input logic [63:0] d);
        logic fb;
        for (int i = 0; i < 64; i++) begin
            fb        = crc_state[0] ^ d[i];
            crc_state = (crc_state >> 1) ^ (fb ? 32'hedb8_8320 : 32'h0);
        end
    endfunction

    // present one word, wait for the transfer, then queue what must come out
    task automatic send_word(input logic [63:0] w, input logic last);
        out_beat_t want;
        in_beat.data = w;
        in_beat.last = last;
        in_valid     = 1'b1;
        do begin
            @(posedge clk);
        end while (!in_ready);
        want.data = scramble_word(w);
        want.kind = kind_data;
        want.last = 1'b0;
        exp_q.push_back(want);
        crc_fold(w);
        if (last) begin
            want.data = {32'h0, ~crc_state}; // inverted with zeros above
            want.kind = kind_crc;
            want.last = 1'b1;
            exp_q.push_back(want);
        end
        @(negedge clk); // next word goes out on this falling edge
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk; // 8 ns period
    end

    // output back-pressure that goes low when two fresh bits are both zero
    initial begin
        logic b0;
        logic b1;
        out_ready = 1'b1;
        forever begin
            @(negedge clk);
            if (stall_en) begin
                ready_rnd = lfsr_next(ready_rnd);
                b0        = ready_rnd[0];
                ready_rnd = lfsr_next(ready_rnd);
                b1        = ready_rnd[0];
                out_ready = b0 | b1;
            end else begin
                out_ready = 1'b1;
            end
        end
    end

    // output monitor sampling just before the rising edge
    always @(posedge clk) begin
        out_beat_t   want_beat;
        int unsigned want_n;
        if (!rst) begin
            if (out_valid && out_beat.kind == kind_crc) begin
                crc_pending = 1'b0; // CRC beat reached the slot
            end
            // input only open in stream state with a free or draining slot
            check_equal("in_ready", 64'(in_ready),
                        64'(!crc_pending && (!out_valid || out_ready)));
            if (in_valid && in_ready && in_beat.last) begin
                crc_pending = 1'b1;
            end
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    fail_run("an output beat arrived with no beat expected");
                end else begin
                    want_beat = exp_q.pop_front();
                    check_equal("out_beat.data", out_beat.data, want_beat.data);
                    check_equal("out_beat.kind", 64'(out_beat.kind), 64'(want_beat.kind));
                    check_equal("out_beat.last", 64'(out_beat.last), 64'(want_beat.last));
                    frame_beats++;
                    if (out_beat.last) begin
                        want_n = beats_q.pop_front();
                        check_equal("frame beat count", 64'(frame_beats), 64'(want_n));
                        frame_beats = 0;
                    end
                end
            end
        end
    end

    // watchdog allowing about four cycles per word plus reset and slack
    initial begin
        int unsigned timeout_cycles;
        timeout_cycles = 10 + 100;
        for (int f = 0; f < NUM_FRAMES; f++) begin
            timeout_cycles += (frame_table[f].len + frame_table[f].gap) * 4;
        end
        repeat (timeout_cycles) @(posedge clk);
        fail_run("timeout: the output stream did not finish in time");
    end

    initial begin
        frame_row_t  row;
        logic [63:0] word;
        rst      = 1'b1;
        in_valid = 1'b0;
        in_beat  = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        check_equal("out_valid", 64'(out_valid), 64'(1'b0)); // idle slot
        check_equal("in_ready", 64'(in_ready), 64'(1'b1));
        rst = 1'b0;
        for (int f = 0; f < NUM_FRAMES; f++) begin
            row      = frame_table[f];
            stall_en <= row.stall;
            if (row.gap != 0) begin
                in_valid = 1'b0;
                repeat (row.gap) @(negedge clk);
            end
            beats_q.push_back(row.exp_beats);
            crc_state = 32'hffff_ffff; // model reseed per frame
            word      = row.first;
            for (int w = 0; w < row.len; w++) begin
                send_word(word, w == row.len - 1);
                word = next_data_word();
            end
        end
        in_valid = 1'b0;
        stall_en <= 1'b0;
        while (exp_q.size() != 0) @(negedge clk);
        @(negedge clk);
        if (!out_valid) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            fail_run("the output stayed valid after the last CRC beat was taken");
        end
    end

endmodule : scr_link_tx_tb

/* run_sim.sh */
#!/usr/bin/env bash
# compile and run the scr_link_tx testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    --top-module scr_link_tx_tb \
    -f scr_link_tx.f \
    -o scr_link_tx_sim

# the log decides the result, not the exit code of the run
./obj_dir/scr_link_tx_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "ALL TESTS PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi

/* scr_link_tx.f */
source/scr_lfsr_pkg.sv
source/scr_frame_pkg.sv
source/lfsr_step.sv
source/scrambler_lane.sv
source/crc_lane.sv
source/frame_combiner.sv
source/scr_link_tx.sv
dv/scr_link_tx_sva.sv
dv/scr_link_tx_tb.sv

/* source/crc_lane.sv */
// CRC-32 frame lane
`timescale 1ns/100ps

module crc_lane import scr_lfsr_pkg::*, scr_frame_pkg::*; #(
    parameter int unsigned DATA_W = 64 // bits of the word covered by the CRC
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             adv,         // word accepted this cycle
    input  logic             frame_start, // accepted word opens a frame
    input  in_beat_t         data_in,     // raw word with its last flag
    output logic [crc_w-1:0] crc_value    // inverted result of the last frame
);

    logic [crc_w-1:0] rem_q;    // running remainder, reflected
    logic [crc_w-1:0] rem_seed; // remainder the word is folded into
    logic [crc_w-1:0] rem_next; // remainder after this word

    assign rem_seed = frame_start ? crc_init : rem_q; // reseed on the first word

    lfsr_step #(
        .DATA_W  (DATA_W),
        .LFSR_W  (crc_w),
        .POLY    (crc_poly),
        .MODE    (mode_galois),
        .REVERSE (1'b1)
    ) u_step (
        .data_in   (data_in.data[DATA_W-1:0]),
        .state_in  (rem_seed),
        .data_out  (),
        .state_out (rem_next)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            rem_q <= crc_init;
        end else if (adv) begin
            rem_q <= rem_next;
        end
    end

    // result register, written once per frame
    always_ff @(posedge clk) begin
        if (rst) begin
            crc_value <= '0;
        end else if (adv && data_in.last) begin
            crc_value <= ~rem_next; // ethernet FCS is the complement
        end
    end

endmodule : crc_lane

/* source/frame_combiner.sv */
// Data and CRC beat combiner
`timescale 1ns/100ps

module frame_combiner import scr_frame_pkg::*; #(
    parameter int unsigned DATA_W = 64 // scrambled word width
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              in_valid,
    input  logic              in_last,     // accepted word closes its frame
    output logic              in_ready,
    output logic              adv,         // input transfer, steps both lanes
    output logic              frame_start, // next accepted word opens a frame
    input  logic [DATA_W-1:0] scr_data,    // registered scrambler output
    input  logic [31:0]       crc_value,   // registered inverted CRC
    output out_beat_t         out_beat,
    output logic              out_valid,
    input  logic              out_ready
);

    comb_state_e state_q;   // input gating state
    beat_kind_e  kind_q;    // what the output slot holds
    logic        slot_free; // slot empty or draining this cycle
    logic        crc_load;  // CRC beat enters the slot this cycle

    assign slot_free = !out_valid || out_ready;
    assign in_ready  = (state_q == st_stream) && slot_free; // blocked until CRC is queued
    assign adv       = in_valid && in_ready;
    assign crc_load  = (state_q == st_crc) && slot_free; // last data beat leaving

    // beat fields come from the lane registers, which hold while the slot waits
    always_comb begin
        out_beat.kind = kind_q;
        out_beat.last = (kind_q == kind_crc); // frame end marker
        if (kind_q == kind_crc) begin
            out_beat.data = beat_data_w'(crc_value); // zeros above bit 31
        end else begin
            out_beat.data = beat_data_w'(scr_data);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q     <= st_stream;
            kind_q      <= kind_data;
            out_valid   <= 1'b0;
            frame_start <= 1'b1; // first word after reset opens a frame
        end else begin
            if (adv) begin
                out_valid <= 1'b1;      // lanes load on the same edge
                kind_q    <= kind_data;
                if (in_last) begin
                    state_q <= st_crc; // hold input until CRC is out
                end
            end else if (crc_load) begin
                out_valid <= 1'b1;     // CRC beat follows straight after
                kind_q    <= kind_crc;
                state_q   <= st_stream;
            end else if (out_ready) begin
                out_valid <= 1'b0; // slot drained, nothing new
            end
            if (adv) begin
                frame_start <= 1'b0;
            end else if (crc_load) begin
                frame_start <= 1'b1; // next word reseeds the CRC
            end
        end
    end

endmodule : frame_combiner

/* source/lfsr_step.sv */
// Unrolled LFSR step
`timescale 1ns/100ps

module lfsr_step import scr_lfsr_pkg::*; #(
    parameter int unsigned       DATA_W  = 64,             // bits shifted per call
    parameter int unsigned       LFSR_W  = 58,             // register width
    parameter logic [LFSR_W-1:0] POLY    = 58'h8000000001, // top term implied
    parameter lfsr_mode_e        MODE    = mode_fibonacci, // shift form
    parameter bit                REVERSE = 1'b1            // lsb first, reflected register
) (
    input  logic [DATA_W-1:0] data_in,
    input  logic [LFSR_W-1:0] state_in,
    output logic [DATA_W-1:0] data_out,
    output logic [LFSR_W-1:0] state_out
);

    // mirror a polynomial for the reflected galois form
    function automatic logic [LFSR_W-1:0] bit_rev(input logic [LFSR_W-1:0] v);
        logic [LFSR_W-1:0] r;
        for (int j = 0; j < LFSR_W; j++) begin
            r[j] = v[LFSR_W-1-j];
        end
        return r;
    endfunction

    localparam logic [LFSR_W-1:0] POLY_REV = bit_rev(POLY); // poly seen from the lsb end

    always_comb begin
        logic [LFSR_W-1:0] s;   // register as it walks through the word
        logic              d;   // current data bit
        logic              fb;  // feedback bit of this shift
        int unsigned       idx; // data bit position for this shift
        s        = state_in;
        data_out = '0;
        for (int i = 0; i < DATA_W; i++) begin
            idx = REVERSE ? i : DATA_W - 1 - i; // lsb first when reversed
            d   = data_in[idx];
            if (MODE == mode_fibonacci) begin
                // top stage plus every tap below it
                fb            = s[LFSR_W-1] ^ (^(s[LFSR_W-2:0] & POLY[LFSR_W-1:1]));
                data_out[idx] = d ^ fb;                  // scrambled bit
                s             = {s[LFSR_W-2:0], d ^ fb}; // self-synchronous, output fed back
            end else if (REVERSE) begin
                fb            = s[0] ^ d;                           // bit leaving the low end
                data_out[idx] = fb;
                s             = (s >> 1) ^ ({LFSR_W{fb}} & POLY_REV); // reflected division
            end else begin
                fb            = s[LFSR_W-1] ^ d;                  // bit leaving the top
                data_out[idx] = fb;
                s             = (s << 1) ^ ({LFSR_W{fb}} & POLY); // normal division
            end
        end
        state_out = s;
    end

endmodule : lfsr_step

/* source/scr_frame_pkg.sv */
// Frame beat types
package scr_frame_pkg;

    // width of the payload field inside the beat structs
    localparam int unsigned beat_data_w = 64;

    // what an output beat carries
    typedef enum logic {
        kind_data = 1'b0, // scrambled data word
        kind_crc  = 1'b1  // unscrambled inverted CRC-32 in the low bits
    } beat_kind_e;

    // one word on the input stream
    typedef struct packed {
        logic [beat_data_w-1:0] data; // raw payload
        logic                   last; // final word of the frame
    } in_beat_t;

    // one word on the output stream
    typedef struct packed {
        logic [beat_data_w-1:0] data; // scrambled word or zero-extended CRC
        beat_kind_e             kind; // tag for the sink
        logic                   last; // only on the CRC beat
    } out_beat_t;

    // combiner control
    typedef enum logic {
        st_stream = 1'b0, // passing data words
        st_crc    = 1'b1  // last word taken, CRC beat not yet in the slot
    } comb_state_e;

endpackage : scr_frame_pkg

/* source/scr_lfsr_pkg.sv */
// LFSR and CRC constants
package scr_lfsr_pkg;

    // form of the unrolled shift in lfsr_step
    typedef enum logic {
        mode_fibonacci = 1'b0, // feedback from taps into bit 0, used by the scrambler
        mode_galois    = 1'b1  // feedback xor'd along the register, used by the CRC
    } lfsr_mode_e;

    // 64b66b self-synchronous scrambler, x^58 + x^39 + 1
    localparam int unsigned scr_w = 58; // scrambler state width

    // top term x^58 is implied by the width
    localparam logic [scr_w-1:0] scr_poly = 58'h8000000001;

    // seed loaded at reset, never reloaded afterwards
    localparam logic [scr_w-1:0] scr_init = '1;

    // ethernet CRC-32
    localparam int unsigned crc_w = 32; // remainder width

    // normal (msb first) form, the lane reflects it through REVERSE
    localparam logic [crc_w-1:0] crc_poly = 32'h04c11db7;

    // remainder at the start of every frame
    localparam logic [crc_w-1:0] crc_init = '1;

endpackage : scr_lfsr_pkg

/* source/scr_link_tx.sv */
// Serial link transmit path
`timescale 1ns/100ps

module scr_link_tx import scr_frame_pkg::*; #(
    parameter int unsigned DATA_W = beat_data_w // payload width, 64 or 32
) (
    input  logic      clk,
    input  logic      rst,
    input  in_beat_t  in_beat,
    input  logic      in_valid,
    output logic      in_ready,
    output out_beat_t out_beat,
    output logic      out_valid,
    input  logic      out_ready
);

    logic              adv;         // input transfer
    logic              frame_start; // CRC reseed request
    logic [DATA_W-1:0] scr_data;    // scrambled word
    logic [31:0]       crc_value;   // inverted CRC of the closed frame

    scrambler_lane #(
        .DATA_W (DATA_W)
    ) u_scr (
        .clk      (clk),
        .rst      (rst),
        .adv      (adv),
        .data_in  (in_beat.data[DATA_W-1:0]),
        .scr_data (scr_data)
    );

    crc_lane #(
        .DATA_W (DATA_W)
    ) u_crc (
        .clk         (clk),
        .rst         (rst),
        .adv         (adv),
        .frame_start (frame_start),
        .data_in     (in_beat),
        .crc_value   (crc_value)
    );

    frame_combiner #(
        .DATA_W (DATA_W)
    ) u_comb (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .in_last     (in_beat.last),
        .in_ready    (in_ready),
        .adv         (adv),
        .frame_start (frame_start),
        .scr_data    (scr_data),
        .crc_value   (crc_value),
        .out_beat    (out_beat),
        .out_valid   (out_valid),
        .out_ready   (out_ready)
    );

endmodule : scr_link_tx

/* source/scrambler_lane.sv */
// 64b66b scrambler lane
`timescale 1ns/100ps

module scrambler_lane import scr_lfsr_pkg::*; #(
    parameter int unsigned DATA_W = 64 // payload width
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              adv,     // word accepted this cycle
    input  logic [DATA_W-1:0] data_in, // raw word
    output logic [DATA_W-1:0] scr_data // scrambled word, held between accepts
);

    logic [scr_w-1:0]  state_q;    // running scrambler state, spans frames
    logic [scr_w-1:0]  state_next; // state after this word
    logic [DATA_W-1:0] data_next;  // scrambled version of data_in

    lfsr_step #(
        .DATA_W  (DATA_W),
        .LFSR_W  (scr_w),
        .POLY    (scr_poly),
        .MODE    (mode_fibonacci),
        .REVERSE (1'b1)
    ) u_step (
        .data_in   (data_in),
        .state_in  (state_q),
        .data_out  (data_next),
        .state_out (state_next)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q  <= scr_init; // fixed seed
            scr_data <= '0;
        end else if (adv) begin
            state_q  <= state_next; // only moves on a real transfer
            scr_data <= data_next;  // stays put while the output stalls
        end
    end

endmodule : scrambler_lane
